// ==== dvi_fb_out.f ====
rtl/dvi_video_pkg.sv
rtl/dvi_axi_pkg.sv
rtl/dvi_timing_gen.sv
rtl/dvi_fb_reader.sv
rtl/dvi_line_fifo.sv
rtl/dvi_pixel_unpack.sv
rtl/tmds_encoder.sv
rtl/dvi_fb_out.sv
test/axi_mem_model.sv
test/tb_dvi_fb_out.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the DVI framebuffer output testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

mkdir -p build
verilator --binary --timing -f dvi_fb_out.f --top-module tb_dvi_fb_out \
    -Mdir build/obj -o sim
./build/obj/sim | tee build/sim.log

if grep -q "Result: FAILED" build/sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
echo "Simulation finished without failure"

// ==== test/dvi_tests.hex ====
// Framebuffer image for a 16x4 frame, one 32-bit word per line, 8 words per row
// Each word holds two RGB565 pixels, the low half is the left pixel
ffff0000
f800001f
07e0f81f
ffe007ff
12345678
9abcdef0
0f0ff0f0
a5a55a5a
00010002
80004000
2000c000
7bef8410
3c3cc3c3
deadbeef
cafef00d
13572468
fedcba98
76543210
5555aaaa
aaaa5555
0000ffff
001f07e0
f80007e0
0421f7de
31a6ce59
6b4d94b2
e71c18e3
4a69b596
8c51739e
c618d6ba
10843def
ffff0001

// ==== test/tb_dvi_fb_out.sv ====
/*
 * Testbench for the DVI framebuffer output. Decodes the TMDS streams and
 * checks pixels, frame shape, AXI addresses, DC balance and underflow
 */
`timescale 1ns/1ps

module tb_dvi_fb_out
    import dvi_axi_pkg::*;
;

    localparam logic [31:0] FB_ADDR = 32'h0000_1000;

    logic        aclk_i = 1'b0;
    logic        rst_n_i = 1'b0;
    logic        starve = 1'b0;
    axi_ar_t     ar;
    logic        ar_valid;
    logic        ar_ready;
    axi_r_t      r;
    logic        r_valid;
    logic        r_ready;
    logic [9:0]  tmds_red;
    logic [9:0]  tmds_green;
    logic [9:0]  tmds_blue;
    logic        underflow;
    logic [31:0] image [0:31];

    int errors = 0;
    int frame_cnt = 0;
    int check_mode = 0;
    int row = 0;
    int col = 0;
    int hs_cnt = 0;
    int vs_cnt = 0;
    int bursts = 0;
    int disp [3];
    logic armed = 1'b0;
    logic in_data = 1'b0;
    logic prev_vs = 1'b0;

    always #5 aclk_i = ~aclk_i;

    dvi_fb_out #(
        .FB_ADDR(FB_ADDR), .H_ACTIVE(16), .H_FRONT(2), .H_SYNC(2), .H_BACK(2),
        .V_ACTIVE(4), .V_FRONT(1), .V_SYNC(1), .V_BACK(1),
        .BURST_BEATS(4), .FIFO_DEPTH(16)
    ) u_dvi_fb_out (
        .aclk_i(aclk_i), .rst_n_i(rst_n_i), .ar_o(ar), .ar_valid_o(ar_valid),
        .ar_ready_i(ar_ready), .r_i(r), .r_valid_i(r_valid), .r_ready_o(r_ready),
        .tmds_red_o(tmds_red), .tmds_green_o(tmds_green), .tmds_blue_o(tmds_blue),
        .underflow_o(underflow)
    );

    axi_mem_model #(.FB_ADDR(FB_ADDR)) u_mem (
        .aclk_i(aclk_i), .rst_n_i(rst_n_i), .starve_i(starve), .ar_i(ar),
        .ar_valid_i(ar_valid), .ar_ready_o(ar_ready), .r_o(r), .r_valid_o(r_valid),
        .r_ready_i(r_ready)
    );

    function automatic logic is_token(input logic [9:0] s);
        return (s == 10'b1101010100) || (s == 10'b0010101011) ||
               (s == 10'b0101010100) || (s == 10'b1010101011);
    endfunction

    // Control bits as {c1, c0}, the blue channel maps them to {vsync, hsync}
    function automatic logic [1:0] token_bits(input logic [9:0] s);
        case (s)
            10'b0010101011: return 2'b01;
            10'b0101010100: return 2'b10;
            10'b1010101011: return 2'b11;
            default:        return 2'b00;
        endcase
    endfunction

    function automatic logic [7:0] decode_symbol(input logic [9:0] s);
        logic [7:0] d;
        logic [7:0] q;
        d    = s[9] ? ~s[7:0] : s[7:0];
        q[0] = d[0];
        for (int i = 1; i < 8; i++) begin
            q[i] = s[8] ? (d[i] ^ d[i-1]) : ~(d[i] ^ d[i-1]);
        end
        return q;
    endfunction

    // RGB565 to RGB888 by repeating the top bits of each field
    function automatic logic [23:0] image_pixel(input int y, input int x);
        logic [15:0] p;
        p = x[0] ? image[y * 8 + x / 2][31:16] : image[y * 8 + x / 2][15:0];
        return {p[15:11], p[15:13], p[10:5], p[10:9], p[4:0], p[4:2]};
    endfunction

    task automatic wait_frames(input int n, output logic ok);
        int t;
        t = 0;
        while (frame_cnt < n && t < 1000) begin
            @(posedge aclk_i);
            t++;
        end
        ok = (frame_cnt >= n);
    endtask

    // Steps through the frames, done stays low when a frame boundary never came
    task automatic run_phases(output logic done);
        logic ok;
        done = 1'b0;
        wait_frames(1, ok);
        if (!ok) begin
            return;
        end
        @(posedge aclk_i);
        check_mode <= 1;
        wait_frames(4, ok);
        if (!ok) begin
            return;
        end
        if (underflow !== 1'b0) begin
            $display("Mismatch underflow_o: got %h expected %h", underflow, 1'b0);
            errors++;
        end
        @(posedge aclk_i);
        check_mode <= 0;
        starve <= 1'b1;
        // One frame drains what was already fetched
        wait_frames(5, ok);
        if (!ok) begin
            return;
        end
        @(posedge aclk_i);
        check_mode <= 2;
        wait_frames(6, ok);
        if (!ok) begin
            return;
        end
        if (underflow !== 1'b1) begin
            $display("underflow_o did not rise while the memory was starved");
            errors++;
        end
        done = 1'b1;
    endtask

    always @(negedge aclk_i) begin
        logic [23:0] got;
        logic [23:0] exp;
        logic [1:0]  c;
        if (!rst_n_i) begin
            if (ar_valid !== 1'b0 || r_ready !== 1'b0) begin
                $display("Mismatch ar_valid_o/r_ready_o in reset: got %h/%h expected 0/0",
                         ar_valid, r_ready);
                errors++;
            end
        end else begin
            // The FIFO holds two lines and never more than one is fetched ahead
            if (r_valid && r_ready !== 1'b1) begin
                $display("Mismatch r_ready_o: got %h expected %h", r_ready, 1'b1);
                errors++;
            end
            if (ar_valid && ar_ready) begin
                exp = 24'(((bursts / 2) % 4) * 32 + (bursts % 2) * 16);
                if (ar.addr != FB_ADDR + 32'(exp)) begin
                    $display("Mismatch ar_o.addr: got %h expected %h", ar.addr,
                             FB_ADDR + 32'(exp));
                    errors++;
                end
                if (ar.len != 8'd3) begin
                    $display("Mismatch ar_o.len: got %h expected %h", ar.len, 8'd3);
                    errors++;
                end
                bursts++;
            end
            if (!is_token(tmds_blue)) begin
                if (is_token(tmds_red) || is_token(tmds_green)) begin
                    $display("Colour channels disagree on data enable");
                    errors++;
                end
                got = {decode_symbol(tmds_red), decode_symbol(tmds_green),
                       decode_symbol(tmds_blue)};
                if (armed && check_mode != 0 && row < 4 && col < 16) begin
                    exp = (check_mode == 2) ? 24'h0 : image_pixel(row, col);
                    if (got != exp) begin
                        $display("Mismatch tmds_red_o/green/blue r%0d c%0d: got %h expected %h",
                                 row, col, got, exp);
                        errors++;
                    end
                end
                disp[0] += 2 * $countones(tmds_red) - 10;
                disp[1] += 2 * $countones(tmds_green) - 10;
                disp[2] += 2 * $countones(tmds_blue) - 10;
                col++;
                in_data = 1'b1;
            end else begin
                if (in_data) begin
                    if (col != 16) begin
                        $display("Mismatch tmds_blue_o data symbols per line: got %h expected %h",
                                 col, 16);
                        errors++;
                    end
                    for (int k = 0; k < 3; k++) begin
                        if (disp[k] > 10 || disp[k] < -10) begin
                            $display("Line %0d channel %0d is out of DC balance by %0d",
                                     row, k, disp[k]);
                            errors++;
                        end
                        disp[k] = 0;
                    end
                    row++;
                    col = 0;
                    in_data = 1'b0;
                end
                if (!is_token(tmds_red) || !is_token(tmds_green)) begin
                    $display("Colour channels disagree on data enable");
                    errors++;
                end else if (token_bits(tmds_red) != 2'b00 ||
                             token_bits(tmds_green) != 2'b00) begin
                    $display("Red or green channel sent a nonzero control token");
                    errors++;
                end
                c = token_bits(tmds_blue);
                hs_cnt += int'(c[0]);
                vs_cnt += int'(c[1]);
                // A frame ends where vsync falls
                if (prev_vs && !c[1]) begin
                    if (armed) begin
                        if (row != 4) begin
                            $display("Mismatch tmds_blue_o lines: got %h expected %h",
                                     row, 4);
                            errors++;
                        end
                        if (hs_cnt != 14) begin
                            $display("Mismatch tmds_blue_o hsync: got %h expected %h",
                                     hs_cnt, 14);
                            errors++;
                        end
                        if (vs_cnt != 22) begin
                            $display("Mismatch tmds_blue_o vsync: got %h expected %h",
                                     vs_cnt, 22);
                            errors++;
                        end
                    end
                    armed = 1'b1;
                    row = 0;
                    hs_cnt = 0;
                    vs_cnt = 0;
                    frame_cnt++;
                end
                prev_vs = c[1];
            end
        end
    end

    initial begin
        logic done;
        disp[0] = 0;
        disp[1] = 0;
        disp[2] = 0;
        $readmemh("test/dvi_tests.hex", image);
        repeat (5) @(posedge aclk_i);
        rst_n_i <= 1'b1;
        run_phases(done);
        if (!done) begin
            $display("Timeout while waiting for a frame boundary");
            errors++;
        end
        $display("Frames: %0d, bursts: %0d, errors: %0d", frame_cnt, bursts, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== test/axi_mem_model.sv ====
/*
 * AXI read slave for the framebuffer image. Serves one burst at a time
 * with random stalls on ar_ready and r_valid, and can be starved
 */
`timescale 1ns/1ps

module axi_mem_model
    import dvi_axi_pkg::*;
#(
    parameter logic [31:0] FB_ADDR = 32'h0000_1000
) (
    input  logic    aclk_i,
    input  logic    rst_n_i,
    input  logic    starve_i,
    input  axi_ar_t ar_i,
    input  logic    ar_valid_i,
    output logic    ar_ready_o,
    output axi_r_t  r_o,
    output logic    r_valid_o,
    input  logic    r_ready_i
);

    logic [31:0] mem [0:31];
    logic        busy;
    int          idx;
    int          left;
    int          seed = 32'hd367_95db;

    initial begin
        $readmemh("test/dvi_tests.hex", mem);
    end

    always @(posedge aclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy       = 1'b0;
            idx        = 0;
            left       = 0;
            ar_ready_o <= 1'b0;
            r_valid_o  <= 1'b0;
            r_o        <= '0;
        end else begin
            if (r_valid_o && r_ready_i) begin
                if (r_o.last) begin
                    busy = 1'b0;
                end else begin
                    idx  = idx + 1;
                    left = left - 1;
                end
            end
            if (ar_valid_i && ar_ready_o) begin
                busy = 1'b1;
                idx  = int'((ar_i.addr - FB_ADDR) >> 2);
                left = int'(ar_i.len);
            end
            ar_ready_o <= !busy && !starve_i && (($random(seed) & 3) != 0);
            // A beat is held until the reader takes it
            if (busy && (!r_valid_o || r_ready_i)) begin
                if (($random(seed) & 7) != 0) begin
                    r_valid_o <= 1'b1;
                    r_o.data  <= mem[idx & 31];
                    r_o.last  <= (left == 0);
                end else begin
                    r_valid_o <= 1'b0;
                end
            end else if (!busy) begin
                r_valid_o <= 1'b0;
            end
        end
    end

endmodule

// ==== rtl/dvi_fb_out.sv ====
/*
 * DVI framebuffer output. Fetches lines over AXI, buffers them, generates
 * video timing and drives three parallel TMDS symbol streams on aclk
 */
`timescale 1ns/1ps

module dvi_fb_out
    import dvi_video_pkg::*;
    import dvi_axi_pkg::*;
#(
    parameter logic [31:0] FB_ADDR     = 32'h01E0_0000,
    parameter int          H_ACTIVE    = 640,
    parameter int          H_FRONT     = 16,
    parameter int          H_SYNC      = 96,
    parameter int          H_BACK      = 48,
    parameter int          V_ACTIVE    = 480,
    parameter int          V_FRONT     = 10,
    parameter int          V_SYNC      = 2,
    parameter int          V_BACK      = 33,
    parameter int          BURST_BEATS = 16,
    parameter int          FIFO_DEPTH  = 1024
) (
    input  logic        aclk_i,
    input  logic        rst_n_i,
    output axi_ar_t     ar_o,
    output logic        ar_valid_o,
    input  logic        ar_ready_i,
    input  axi_r_t      r_i,
    input  logic        r_valid_i,
    output logic        r_ready_o,
    output logic [9:0]  tmds_red_o,
    output logic [9:0]  tmds_green_o,
    output logic [9:0]  tmds_blue_o,
    output logic        underflow_o
);

    video_ctrl_t ctrl;
    video_px_t   px;
    logic        line_req;
    logic        push;
    logic [31:0] push_data;
    logic        pop;
    logic [31:0] pop_data;
    logic        fifo_empty;
    logic        fifo_full;

    dvi_timing_gen #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) u_timing_gen (
        .aclk_i(aclk_i), .rst_n_i(rst_n_i), .ctrl_o(ctrl), .line_req_o(line_req)
    );

    dvi_fb_reader #(
        .FB_ADDR(FB_ADDR), .H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE),
        .BURST_BEATS(BURST_BEATS)
    ) u_fb_reader (
        .aclk_i(aclk_i), .rst_n_i(rst_n_i), .line_req_i(line_req),
        .ar_o(ar_o), .ar_valid_o(ar_valid_o), .ar_ready_i(ar_ready_i),
        .r_i(r_i), .r_valid_i(r_valid_i), .r_ready_o(r_ready_o),
        .fifo_full_i(fifo_full), .push_o(push), .push_data_o(push_data)
    );

    dvi_line_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_line_fifo (
        .aclk_i(aclk_i), .rst_n_i(rst_n_i), .push_i(push), .push_data_i(push_data),
        .pop_i(pop), .pop_data_o(pop_data), .empty_o(fifo_empty), .full_o(fifo_full)
    );

    dvi_pixel_unpack u_pixel_unpack (
        .aclk_i(aclk_i), .rst_n_i(rst_n_i), .ctrl_i(ctrl), .fifo_empty_i(fifo_empty),
        .pop_o(pop), .pop_data_i(pop_data), .px_o(px), .underflow_o(underflow_o)
    );

    // Only the blue channel carries the sync bits in blanking
    tmds_encoder u_tmds_blue (
        .aclk_i(aclk_i), .rst_n_i(rst_n_i), .de_i(px.ctrl.de), .data_i(px.color.blue),
        .ctrl_i({px.ctrl.vsync, px.ctrl.hsync}), .tmds_o(tmds_blue_o)
    );

    tmds_encoder u_tmds_green (
        .aclk_i(aclk_i), .rst_n_i(rst_n_i), .de_i(px.ctrl.de), .data_i(px.color.green),
        .ctrl_i(2'b00), .tmds_o(tmds_green_o)
    );

    tmds_encoder u_tmds_red (
        .aclk_i(aclk_i), .rst_n_i(rst_n_i), .de_i(px.ctrl.de), .data_i(px.color.red),
        .ctrl_i(2'b00), .tmds_o(tmds_red_o)
    );

endmodule

// ==== rtl/tmds_encoder.sv ====
/*
 * DVI 1.0 TMDS encoder for one colour channel. Data periods use the
 * transition-minimizing and DC-balancing stages, blanking sends control tokens
 */
`timescale 1ns/1ps

module tmds_encoder (
    input  logic       aclk_i,
    input  logic       rst_n_i,
    input  logic       de_i,
    input  logic [7:0] data_i,
    input  logic [1:0] ctrl_i,
    output logic [9:0] tmds_o
);

    localparam logic [9:0] TOKEN_00 = 10'b1101010100;
    localparam logic [9:0] TOKEN_01 = 10'b0010101011;
    localparam logic [9:0] TOKEN_10 = 10'b0101010100;
    localparam logic [9:0] TOKEN_11 = 10'b1010101011;

    logic              [8:0] q_m;
    logic              [3:0] n1_d;
    logic              [3:0] n1_q;
    logic              [3:0] n0_q;
    logic                    use_xnor;
    logic signed       [4:0] bal;
    logic signed       [4:0] cnt_q;
    logic signed       [4:0] cnt_d;
    logic              [9:0] sym_d;

    // First stage picks XOR or XNOR chaining to cut transitions
    always_comb begin
        n1_d     = 4'($countones(data_i));
        use_xnor = (n1_d > 4'd4) || ((n1_d == 4'd4) && !data_i[0]);
        q_m[0]   = data_i[0];
        for (int i = 1; i < 8; i++) begin
            q_m[i] = use_xnor ? ~(q_m[i-1] ^ data_i[i]) : (q_m[i-1] ^ data_i[i]);
        end
        q_m[8] = ~use_xnor;
        n1_q   = 4'($countones(q_m[7:0]));
        n0_q   = 4'd8 - n1_q;
        bal    = $signed({1'b0, n1_q}) - $signed({1'b0, n0_q});
    end

    // Second stage inverts the word when that pulls the running disparity toward zero
    always_comb begin
        if ((cnt_q == 5'sd0) || (n1_q == n0_q)) begin
            sym_d = {~q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
            cnt_d = q_m[8] ? cnt_q + bal : cnt_q - bal;
        end else if ((!cnt_q[4] && (n1_q > n0_q)) || (cnt_q[4] && (n0_q > n1_q))) begin
            sym_d = {1'b1, q_m[8], ~q_m[7:0]};
            cnt_d = cnt_q + $signed({3'b000, q_m[8], 1'b0}) - bal;
        end else begin
            sym_d = {1'b0, q_m[8], q_m[7:0]};
            cnt_d = cnt_q - $signed({3'b000, ~q_m[8], 1'b0}) + bal;
        end
    end

    always_ff @(posedge aclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            tmds_o <= TOKEN_00;
            cnt_q  <= '0;
        end else if (de_i) begin
            tmds_o <= sym_d;
            cnt_q  <= cnt_d;
        end else begin
            cnt_q <= '0;
            case (ctrl_i)
                2'b00:   tmds_o <= TOKEN_00;
                2'b01:   tmds_o <= TOKEN_01;
                2'b10:   tmds_o <= TOKEN_10;
                default: tmds_o <= TOKEN_11;
            endcase
        end
    end

endmodule

// ==== rtl/dvi_pixel_unpack.sv ====
/*
 * Pixel unpacker. Pops one word per pixel pair, shows the low RGB565 half
 * first, expands to RGB888 and blanks pixels outside de or on underflow
 */
`timescale 1ns/1ps

module dvi_pixel_unpack
    import dvi_video_pkg::*;
(
    input  logic        aclk_i,
    input  logic        rst_n_i,
    input  video_ctrl_t ctrl_i,
    input  logic        fifo_empty_i,
    output logic        pop_o,
    input  logic [31:0] pop_data_i,
    output video_px_t   px_o,
    output logic        underflow_o
);

    logic    phase_q;
    logic    need_word;
    logic    hi_ok_q;
    rgb565_t hi_q;
    rgb888_t color_d;

    // Top bits are repeated into the low bits so full scale maps to 255
    function automatic rgb888_t expand(input rgb565_t px);
        rgb888_t res;
        res.red   = {px.red, px.red[4:2]};
        res.green = {px.green, px.green[5:4]};
        res.blue  = {px.blue, px.blue[4:2]};
        return res;
    endfunction

    assign need_word = ctrl_i.de && !phase_q;
    assign pop_o     = need_word && !fifo_empty_i;

    always_comb begin
        color_d = '0;
        if (need_word && !fifo_empty_i) begin
            color_d = expand(rgb565_t'(pop_data_i[15:0]));
        end else if (ctrl_i.de && phase_q && hi_ok_q) begin
            color_d = expand(hi_q);
        end
    end

    always_ff @(posedge aclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            phase_q     <= 1'b0;
            hi_ok_q     <= 1'b0;
            px_o        <= '0;
            underflow_o <= 1'b0;
        end else begin
            // Phase restarts on every line since H_ACTIVE is even
            phase_q    <= ctrl_i.de && !phase_q;
            px_o.ctrl  <= ctrl_i;
            px_o.color <= color_d;
            if (need_word) begin
                hi_ok_q <= !fifo_empty_i;
            end
            if (need_word && fifo_empty_i) begin
                underflow_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge aclk_i) begin
        if (need_word) begin
            hi_q <= rgb565_t'(pop_data_i[31:16]);
        end
    end

endmodule

// ==== rtl/dvi_line_fifo.sv ====
/*
 * Synchronous word FIFO for framebuffer lines, first-word fall-through.
 * Pushes while full and pops while empty are ignored
 */
`timescale 1ns/1ps

module dvi_line_fifo #(
    parameter int FIFO_DEPTH = 1024
) (
    input  logic        aclk_i,
    input  logic        rst_n_i,
    input  logic        push_i,
    input  logic [31:0] push_data_i,
    input  logic        pop_i,
    output logic [31:0] pop_data_o,
    output logic        empty_o,
    output logic        full_o
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [31:0]      mem_q [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_push;
    logic             do_pop;

    assign empty_o    = (count_q == '0);
    assign full_o     = (count_q == CNT_W'(FIFO_DEPTH));
    assign do_push    = push_i && !full_o;
    assign do_pop     = pop_i && !empty_o;
    assign pop_data_o = mem_q[rd_ptr_q];

    always_ff @(posedge aclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q <= count_q + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

    always_ff @(posedge aclk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

endmodule

// ==== rtl/dvi_fb_reader.sv ====
/*
 * Framebuffer line reader. Turns each line request into AXI read bursts
 * and forwards the returned beats into the line FIFO
 */
`timescale 1ns/1ps

module dvi_fb_reader
    import dvi_video_pkg::*;
    import dvi_axi_pkg::*;
#(
    parameter logic [31:0] FB_ADDR     = 32'h01E0_0000,
    parameter int          H_ACTIVE    = 640,
    parameter int          V_ACTIVE    = 480,
    parameter int          BURST_BEATS = 16
) (
    input  logic        aclk_i,
    input  logic        rst_n_i,
    input  logic        line_req_i,
    output axi_ar_t     ar_o,
    output logic        ar_valid_o,
    input  logic        ar_ready_i,
    input  axi_r_t      r_i,
    input  logic        r_valid_i,
    output logic        r_ready_o,
    input  logic        fifo_full_i,
    output logic        push_o,
    output logic [31:0] push_data_o
);

    localparam int WORDS_PER_LINE  = H_ACTIVE / PIXELS_PER_WORD;
    localparam int LINE_BYTES      = WORDS_PER_LINE * AXI_WORD_BYTES;
    localparam int WORD_W          = $clog2(WORDS_PER_LINE + 1);
    localparam int LINE_W          = $clog2(V_ACTIVE + 1);
    localparam int MAX_OUTSTANDING = 2;

    logic [1:0]        pending_q;
    logic [1:0]        outst_q;
    logic [LINE_W-1:0] line_q;
    logic [WORD_W-1:0] word_q;
    logic [WORD_W-1:0] remain;
    logic [WORD_W-1:0] beats;
    logic [WORD_W-1:0] word_next;
    logic              run_q;
    logic              can_issue;
    logic              line_take;
    logic              req_take;
    logic              ar_fire;
    logic              r_fire;

    assign ar_fire   = ar_valid_o && ar_ready_i;
    assign r_fire    = r_valid_i && r_ready_o;
    assign r_ready_o = run_q && !fifo_full_i;

    assign push_o      = r_fire;
    assign push_data_o = r_i.data;

    // A new line may only start from a queued request
    assign can_issue = !ar_valid_o && (outst_q < 2'(MAX_OUTSTANDING)) &&
                       ((word_q != '0) || (pending_q != '0));
    assign line_take = can_issue && (word_q == '0);
    assign req_take  = line_req_i && (pending_q != 2'd2);

    // The final burst of a line is shortened to what is left
    assign remain    = WORD_W'(WORDS_PER_LINE) - word_q;
    assign beats     = (remain > WORD_W'(BURST_BEATS)) ? WORD_W'(BURST_BEATS) : remain;
    assign word_next = word_q + WORD_W'(ar_o.len) + 1'b1;

    always_ff @(posedge aclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            run_q      <= 1'b0;
            pending_q  <= '0;
            outst_q    <= '0;
            line_q     <= '0;
            word_q     <= '0;
            ar_valid_o <= 1'b0;
        end else begin
            run_q     <= 1'b1;
            pending_q <= pending_q + 2'(req_take) - 2'(line_take);
            outst_q   <= outst_q + 2'(ar_fire) - 2'(r_fire && r_i.last);
            if (can_issue) begin
                ar_valid_o <= 1'b1;
            end else if (ar_fire) begin
                ar_valid_o <= 1'b0;
                if (word_next == WORD_W'(WORDS_PER_LINE)) begin
                    word_q <= '0;
                    line_q <= (line_q == LINE_W'(V_ACTIVE - 1)) ? '0 : line_q + 1'b1;
                end else begin
                    word_q <= word_next;
                end
            end
        end
    end

    // Address and length are loaded once and held until the handshake
    always_ff @(posedge aclk_i) begin
        if (can_issue) begin
            ar_o.addr <= FB_ADDR + 32'(line_q * LINE_BYTES) + 32'(word_q * AXI_WORD_BYTES);
            ar_o.len  <= 8'(beats - 1'b1);
        end
    end

endmodule

// ==== rtl/dvi_timing_gen.sv ====
/*
 * DVI video timing generator. Runs the horizontal and vertical counters
 * and registers data enable, sync pulses and the line fetch request
 */
`timescale 1ns/1ps

module dvi_timing_gen
    import dvi_video_pkg::*;
#(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33
) (
    input  logic        aclk_i,
    input  logic        rst_n_i,
    output video_ctrl_t ctrl_o,
    output logic        line_req_o
);

    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int H_W     = $clog2(H_TOTAL);
    localparam int V_W     = $clog2(V_TOTAL);

    logic [H_W-1:0] h_q;
    logic [V_W-1:0] v_q;
    logic           h_last;
    logic           v_last;
    logic           next_active;
    logic           req_d;
    video_ctrl_t    ctrl_d;

    assign h_last = (h_q == H_W'(H_TOTAL - 1));
    assign v_last = (v_q == V_W'(V_TOTAL - 1));

    // Lines run active, front porch, sync, back porch in both directions
    always_comb begin
        ctrl_d.de    = (h_q < H_W'(H_ACTIVE)) && (v_q < V_W'(V_ACTIVE));
        ctrl_d.hsync = (h_q >= H_W'(H_ACTIVE + H_FRONT)) &&
                       (h_q <  H_W'(H_ACTIVE + H_FRONT + H_SYNC));
        ctrl_d.vsync = (v_q >= V_W'(V_ACTIVE + V_FRONT)) &&
                       (v_q <  V_W'(V_ACTIVE + V_FRONT + V_SYNC));
        // The last back porch line counts too, it prefetches line 0
        next_active  = (v_q < V_W'(V_ACTIVE - 1)) || v_last;
        req_d        = (h_q == H_W'(H_ACTIVE)) && next_active;
    end

    // Counters come out of reset at the top of vertical blanking
    always_ff @(posedge aclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            h_q        <= '0;
            v_q        <= V_W'(V_ACTIVE);
            ctrl_o     <= '0;
            line_req_o <= 1'b0;
        end else begin
            ctrl_o     <= ctrl_d;
            line_req_o <= req_d;
            if (h_last) begin
                h_q <= '0;
                v_q <= v_last ? '0 : v_q + 1'b1;
            end else begin
                h_q <= h_q + 1'b1;
            end
        end
    end

endmodule

// ==== rtl/dvi_axi_pkg.sv ====
/*
 * AXI4 read channel payloads used on the framebuffer memory port.
 * Fixed fields like id, size and burst type live in the memory system
 */
package dvi_axi_pkg;

    // Byte size of one 32-bit data beat
    localparam int AXI_WORD_BYTES = 4;

    // Read address channel payload
    typedef struct packed {
        logic [31:0] addr;
        logic [7:0]  len;
    } axi_ar_t;

    // Read data channel payload
    typedef struct packed {
        logic [31:0] data;
        logic        last;
    } axi_r_t;

endpackage

// ==== rtl/dvi_video_pkg.sv ====
/*
 * Display video types: sync and data enable controls, framebuffer and
 * output pixel formats, and the payload handed from unpack to the encoders
 */
package dvi_video_pkg;

    // Framebuffer words carry two RGB565 pixels, low half first
    localparam int PIXELS_PER_WORD = 2;

    // Per pixel clock control bits, sync pulses are active high
    typedef struct packed {
        logic de;
        logic hsync;
        logic vsync;
    } video_ctrl_t;

    // One framebuffer pixel as stored in memory
    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } rgb565_t;

    // One output pixel after colour expansion
    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb888_t;

    typedef struct packed {
        video_ctrl_t ctrl;
        rgb888_t     color;
    } video_px_t;

endpackage
